// File: tb.f
+incdir+logic
logic/aggre_pkg.sv
logic/aggre_datatype_comparator.sv
logic/aggre_concat_line_scheduler.sv
logic/aggre_bpg.sv
logic/aggre_concat_top.sv
tb/aggre_pipe_model.sv
tb/aggre_tb.sv

// File: Bender.yml
package:
  name: aggre_concat

sources:
  - include_dirs:
      - logic
    files:
      - logic/aggre_pkg.sv
      - logic/aggre_datatype_comparator.sv
      - logic/aggre_concat_line_scheduler.sv
      - logic/aggre_bpg.sv
      - logic/aggre_concat_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/aggre_pipe_model.sv
      - tb/aggre_tb.sv

// File: tb/aggre_tb.sv
`timescale 1ns/100ps

`include "aggre_config.svh"

module aggre_tb;

    import aggre_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int ROUNDS     = 8;
    localparam int ROUND_CYC  = 200;

    logic      aggre_clk;
    logic      aggre_clk_rst_n;
    sch_cfg_t  cfg;
    logic      start_sch_pulse;
    pipe_dt_t  pipe_dt [`AGGRE_PIPE_NUM];
    pipe_evt_t pipe_evt [`AGGRE_PIPE_NUM];
    pipe_vec_t up_state;
    logic      bpg_up_state;
    logic      end_sch_pulse;
    logic      sch_data_type_align_fail_int;

    int        seed       = 32'h2cd49287;
    logic      round_ok   = 1'b1;   // Expected result of the type check
    logic      in_round   = 1'b0;
    pipe_vec_t up_q       = '0;
    logic      bpg_q      = 1'b0;
    int        lines_left = 0;
    int        err_cnt    = 0;
    int        grant_cnt  = 0;
    logic      line_end_any;
    logic      master_up;
    pipe_idx_t exp_order [$];       // Pipes still to be granted

    aggre_concat_top aggre_concat_top_i (
        .aggre_clk                    (aggre_clk),
        .aggre_clk_rst_n              (aggre_clk_rst_n),
        .cfg                          (cfg),
        .start_sch_pulse              (start_sch_pulse),
        .pipe_dt                      (pipe_dt),
        .pipe_evt                     (pipe_evt),
        .up_state                     (up_state),
        .bpg_up_state                 (bpg_up_state),
        .end_sch_pulse                (end_sch_pulse),
        .sch_data_type_align_fail_int (sch_data_type_align_fail_int)
    );

    aggre_pipe_model u_pipes (
        .aggre_clk (aggre_clk),
        .up_state  (up_state),
        .pipe_evt  (pipe_evt)
    );

    initial begin
        aggre_clk = 1'b0;
        forever #(CLK_PERIOD / 2) aggre_clk = ~aggre_clk;
    end

    // BPG line end stays inside the top level
    assign line_end_any = pipe_evt[0].line_end | pipe_evt[1].line_end | pipe_evt[2].line_end |
                          pipe_evt[3].line_end | aggre_concat_top_i.bpg_evt.line_end;
    assign master_up    = cfg.pipe_mask_bitmap[cfg.master_pipe] ? bpg_up_state
                                                                 : up_state[cfg.master_pipe];

    task automatic value_error(input string name, input int exp, input int got);
        err_cnt++;
        $display("MISMATCH at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
    endtask

    task automatic event_error(input string what);
        err_cnt++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    // Compare a rising grant with the head of the expected order
    task automatic record_grant(input int pipe, input logic via_bpg);
        pipe_idx_t exp;
        grant_cnt++;
        if (exp_order.size() == 0) begin
            event_error("grant with no enabled pipe left to serve");
        end else begin
            exp = exp_order.pop_front();
            if (via_bpg) begin
                a_bpg_pipe: assert (cfg.pipe_mask_bitmap[exp])
                    else event_error("BPG granted while the next pipe is unmasked");
            end else begin
                a_order: assert (pipe == int'(exp))
                    else value_error("granted pipe", exp, pipe);
            end
        end
    endtask

    // ==================================================
    // Round model
    // ==================================================

    always @(posedge aggre_clk) begin
        pipe_idx_t p;
        up_q  <= up_state;
        bpg_q <= bpg_up_state;
        if (aggre_clk_rst_n && start_sch_pulse && round_ok) begin
            in_round   <= 1'b1;
            lines_left <= $countones(cfg.pipe_concat_en);
            exp_order.delete();
            // Walking on from the master meets the enabled pipes in serving order
            for (int k = 0; k < `AGGRE_PIPE_NUM; k++) begin
                p = cfg.master_pipe + pipe_idx_t'(k);
                if (cfg.pipe_concat_en[p]) begin
                    exp_order.push_back(p);
                end
            end
        end
        if (aggre_clk_rst_n && in_round) begin
            for (int i = 0; i < `AGGRE_PIPE_NUM; i++) begin
                if (up_state[i] && !up_q[i]) begin
                    record_grant(i, 1'b0);
                end
            end
            if (bpg_up_state && !bpg_q) begin
                record_grant(-1, 1'b1);
            end
            if (line_end_any && lines_left > 0) begin
                lines_left <= lines_left - 1;
            end
            if (end_sch_pulse) begin
                in_round <= 1'b0;
                a_all_served: assert (exp_order.size() == 0)
                    else event_error("round ended with enabled pipes not served");
            end
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    a_reset: assert property (@(posedge aggre_clk)
        !aggre_clk_rst_n && $past(!aggre_clk_rst_n) |->
            ({up_state, bpg_up_state, end_sch_pulse, sch_data_type_align_fail_int} == '0))
        else value_error("outputs in reset", 0,
                         {up_state, bpg_up_state, end_sch_pulse, sch_data_type_align_fail_int});
    a_master: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $past(start_sch_pulse && round_ok, 2) |-> master_up)
        else value_error("master grant", 1, 0);
    a_one_grant: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $onehot0({bpg_up_state, up_state}))
        else event_error("more than one grant high");
    a_no_stray: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        (up_state != '0 || bpg_up_state) |-> in_round)
        else event_error("grant issued outside an accepted round");
    a_mask_up: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        (up_state & cfg.pipe_mask_bitmap) == '0)
        else value_error("up_state of masked pipes", 0, up_state & cfg.pipe_mask_bitmap);
    a_bpg_len: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $fell(bpg_up_state) |-> $past(bpg_up_state, `AGGRE_BPG_ACK_DLY + 1) &&
                                !$past(bpg_up_state, `AGGRE_BPG_ACK_DLY + 2))
        else event_error("BPG grant did not last until the BPG ack");
    a_end_once: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $past(end_sch_pulse) |-> !end_sch_pulse)
        else value_error("end_sch_pulse", 0, 1);
    a_end_late: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        end_sch_pulse |-> $past(line_end_any) && lines_left == 0)
        else event_error("end_sch_pulse before the last line end of the round");
    a_end_due: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $past(line_end_any && lines_left == 1) |-> end_sch_pulse)
        else value_error("end_sch_pulse", 1, 0);
    a_fail_int: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $past(start_sch_pulse && cfg.aggre_mode == AGGRE_MODE_CONCAT) |->
            sch_data_type_align_fail_int == !$past(round_ok))
        else value_error("sch_data_type_align_fail_int", !$sampled(sch_data_type_align_fail_int),
                         $sampled(sch_data_type_align_fail_int));
    a_fail_hold: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $past(cfg.aggre_mode != AGGRE_MODE_CONCAT) |-> $stable(sch_data_type_align_fail_int))
        else value_error("sch_data_type_align_fail_int", !$sampled(sch_data_type_align_fail_int),
                         $sampled(sch_data_type_align_fail_int));

    // ==================================================
    // Stimulus
    // ==================================================

    task automatic run_round(input pipe_vec_t en, input pipe_vec_t mask, input pipe_idx_t master,
                             input aggre_mode_e mode, input logic bad_dt);
        data_type_t dt;
        dt = data_type_t'($random(seed));
        @(posedge aggre_clk);
        cfg <= '{aggre_mode: mode, pipe_concat_en: en, pipe_mask_bitmap: mask,
                 master_pipe: master, pipe_rdy_bitmap: en};
        for (int i = 0; i < `AGGRE_PIPE_NUM; i++) begin
            // Pipes not ready carry a foreign type
            pipe_dt[i] <= '{valid: 1'b1, data_type: en[i] ? dt : ~dt};
        end
        if (bad_dt) begin
            pipe_dt[3] <= '{valid: 1'b1, data_type: dt + 1'b1};
        end
        @(posedge aggre_clk);
        start_sch_pulse <= 1'b1;
        round_ok        <= !bad_dt;
        @(posedge aggre_clk);
        start_sch_pulse <= 1'b0;
        if (bad_dt) begin
            cfg.aggre_mode <= AGGRE_MODE_SPLIT;    // Interrupt must now hold
            repeat (8) @(posedge aggre_clk);
        end else begin
            while (!end_sch_pulse) begin
                @(posedge aggre_clk);
            end
        end
    endtask

    initial begin
        aggre_clk_rst_n = 1'b0;
        cfg             = '0;
        start_sch_pulse = 1'b0;
        for (int i = 0; i < `AGGRE_PIPE_NUM; i++) begin
            pipe_dt[i] = '0;
        end
        repeat (4) @(posedge aggre_clk);
        aggre_clk_rst_n <= 1'b1;
        run_round(4'b1111, 4'b0000, 2'd0, AGGRE_MODE_CONCAT, 1'b0);
        run_round(4'b1111, 4'b0100, 2'd2, AGGRE_MODE_CONCAT, 1'b0);  // Masked master
        run_round(4'b1011, 4'b0000, 2'd3, AGGRE_MODE_CONCAT, 1'b0);
        run_round(4'b0110, 4'b0010, 2'd2, AGGRE_MODE_CONCAT, 1'b0);
        run_round(4'b1111, 4'b0000, 2'd1, AGGRE_MODE_CONCAT, 1'b1);
        run_round(4'b1111, 4'b0000, 2'd1, AGGRE_MODE_SPLIT, 1'b1);
        run_round(4'b1101, 4'b1001, 2'd0, AGGRE_MODE_CONCAT, 1'b0);
        run_round(4'b0010, 4'b0000, 2'd1, AGGRE_MODE_CONCAT, 1'b0);  // Single pipe
        repeat (4) @(posedge aggre_clk);
        $display("Summary: %0d grants checked, %0d errors", grant_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(ROUNDS * ROUND_CYC * CLK_PERIOD);
        $display("Watchdog expired before the last round finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: tb/aggre_pipe_model.sv
`timescale 1ns/100ps

`include "aggre_config.svh"

module aggre_pipe_model (
    input  logic                 aggre_clk,
    input  aggre_pkg::pipe_vec_t up_state,
    output aggre_pkg::pipe_evt_t pipe_evt [`AGGRE_PIPE_NUM]
);

    import aggre_pkg::*;

    int seed = 32'h2cd49287;    // Shared, only one pipe is granted at a time

    for (genvar i = 0; i < `AGGRE_PIPE_NUM; i++) begin : g_pipe
        pipe_evt_t evt = '0;
        int        ack_dly;
        int        line_len;

        assign pipe_evt[i] = evt;

        // A high grant at an edge starts one line
        initial begin
            forever begin
                @(posedge aggre_clk);
                if (up_state[i]) begin
                    ack_dly  = 1 + $unsigned($random(seed)) % 4;    // 1 to 4
                    line_len = 2 + $unsigned($random(seed)) % 7;    // 2 to 8
                    repeat (ack_dly - 1) @(posedge aggre_clk);
                    evt.ack <= 1'b1;
                    @(posedge aggre_clk);
                    evt.ack <= 1'b0;
                    repeat (line_len - 1) @(posedge aggre_clk);
                    evt.line_end <= 1'b1;
                    @(posedge aggre_clk);
                    evt.line_end <= 1'b0;
                end
            end
        end
    end

endmodule

// File: logic/aggre_concat_top.sv
`timescale 1ns/100ps

`include "aggre_config.svh"

module aggre_concat_top (
    input  logic                 aggre_clk,
    input  logic                 aggre_clk_rst_n,
    input  aggre_pkg::sch_cfg_t  cfg,
    input  logic                 start_sch_pulse,
    input  aggre_pkg::pipe_dt_t  pipe_dt [`AGGRE_PIPE_NUM],
    input  aggre_pkg::pipe_evt_t pipe_evt [`AGGRE_PIPE_NUM],
    output aggre_pkg::pipe_vec_t up_state,
    output logic                 bpg_up_state,
    output logic                 end_sch_pulse,
    output logic                 sch_data_type_align_fail_int
);

    import aggre_pkg::*;

    pipe_evt_t bpg_evt;     // BPG response back to the scheduler

    aggre_concat_line_scheduler u_sch (
        .aggre_clk                    (aggre_clk),
        .aggre_clk_rst_n              (aggre_clk_rst_n),
        .cfg                          (cfg),
        .start_sch_pulse              (start_sch_pulse),
        .pipe_dt                      (pipe_dt),
        .pipe_evt                     (pipe_evt),
        .bpg_evt                      (bpg_evt),
        .up_state                     (up_state),
        .bpg_up_state                 (bpg_up_state),
        .end_sch_pulse                (end_sch_pulse),
        .sch_data_type_align_fail_int (sch_data_type_align_fail_int)
    );

    // Stands in for masked pipes
    aggre_bpg u_bpg (
        .aggre_clk       (aggre_clk),
        .aggre_clk_rst_n (aggre_clk_rst_n),
        .bpg_up_state    (bpg_up_state),
        .bpg_evt         (bpg_evt)
    );

endmodule

// File: logic/aggre_bpg.sv
`timescale 1ns/100ps

`include "aggre_config.svh"

module aggre_bpg (
    input  logic                 aggre_clk,
    input  logic                 aggre_clk_rst_n,
    input  logic                 bpg_up_state,
    output aggre_pkg::pipe_evt_t bpg_evt
);

    localparam int CNT_W = $clog2(`AGGRE_BPG_LINE_LEN + 1);

    logic             grant_d;
    logic             grant_rise;
    logic             wait_ack;     // Counting towards the ack
    logic             wait_end;     // Counting towards the line end
    logic [CNT_W-1:0] cnt;

    assign grant_rise = bpg_up_state & ~grant_d;

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            grant_d  <= 1'b0;
            wait_ack <= 1'b0;
            wait_end <= 1'b0;
            cnt      <= '0;
        end else begin
            grant_d <= bpg_up_state;
            if (grant_rise) begin
                wait_ack <= 1'b1;
                wait_end <= 1'b0;
                cnt      <= CNT_W'(1);
            end else if (wait_ack && (cnt == CNT_W'(`AGGRE_BPG_ACK_DLY))) begin
                wait_ack <= 1'b0;           // Ack cycle, line timing starts
                wait_end <= 1'b1;
                cnt      <= CNT_W'(1);
            end else if (wait_end && (cnt == CNT_W'(`AGGRE_BPG_LINE_LEN))) begin
                wait_end <= 1'b0;           // Rest until next grant
                cnt      <= '0;
            end else if (wait_ack || wait_end) begin
                cnt <= cnt + CNT_W'(1);
            end
        end
    end

    // One-cycle pulses decoded from the counter
    assign bpg_evt.ack      = wait_ack && (cnt == CNT_W'(`AGGRE_BPG_ACK_DLY));
    assign bpg_evt.line_end = wait_end && (cnt == CNT_W'(`AGGRE_BPG_LINE_LEN));

endmodule

// File: logic/aggre_concat_line_scheduler.sv
`timescale 1ns/100ps

`include "aggre_config.svh"

module aggre_concat_line_scheduler (
    input  logic                 aggre_clk,
    input  logic                 aggre_clk_rst_n,
    input  aggre_pkg::sch_cfg_t  cfg,
    input  logic                 start_sch_pulse,
    input  aggre_pkg::pipe_dt_t  pipe_dt [`AGGRE_PIPE_NUM],
    input  aggre_pkg::pipe_evt_t pipe_evt [`AGGRE_PIPE_NUM],
    input  aggre_pkg::pipe_evt_t bpg_evt,
    output aggre_pkg::pipe_vec_t up_state,
    output logic                 bpg_up_state,
    output logic                 end_sch_pulse,
    output logic                 sch_data_type_align_fail_int
);

    import aggre_pkg::*;

    sch_state_e sch_cs;
    sch_state_e sch_ns;

    pipe_vec_t  cmp_sel;
    logic       comp_fail;
    logic       start_accept;

    pipe_vec_t  evt_ack;
    pipe_vec_t  evt_line_end;
    logic       ack_hit;
    logic       line_end_hit;

    pipe_vec_t  order_vld;                          // Unserved entries
    pipe_idx_t  order_pipe [`AGGRE_PIPE_NUM];
    pipe_vec_t  rot_vld;
    pipe_idx_t  rot_pipe [`AGGRE_PIPE_NUM];
    pipe_idx_t  group_index;
    pipe_idx_t  rot_index;
    pipe_idx_t  next_pipe;
    logic       master_flag;
    pipe_vec_t  grant;                              // One-hot, before BPG split

    // ==================================================
    // Data type alignment check
    // ==================================================

    assign cmp_sel      = cfg.pipe_rdy_bitmap & {`AGGRE_PIPE_NUM{start_sch_pulse}};
    assign start_accept = start_sch_pulse & ~comp_fail;

    aggre_datatype_comparator u_dt_cmp (
        .in_dt     (pipe_dt),
        .in_sel    (cmp_sel),
        .comp_fail (comp_fail)
    );

    // Only concat mode reports a misaligned start
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            sch_data_type_align_fail_int <= 1'b0;
        end else if (cfg.aggre_mode == AGGRE_MODE_CONCAT) begin
            sch_data_type_align_fail_int <= comp_fail;
        end
    end

    // Masked pipes listen to the BPG instead of their own pipe
    always_comb begin
        for (int i = 0; i < `AGGRE_PIPE_NUM; i++) begin
            evt_ack[i]      = cfg.pipe_concat_en[i] &
                              (cfg.pipe_mask_bitmap[i] ? bpg_evt.ack : pipe_evt[i].ack);
            evt_line_end[i] = cfg.pipe_concat_en[i] &
                              (cfg.pipe_mask_bitmap[i] ? bpg_evt.line_end
                                                       : pipe_evt[i].line_end);
        end
    end

    assign ack_hit      = |(evt_ack & grant);   // Ack from the granted source only
    assign line_end_hit = |evt_line_end;

    // ==================================================
    // Order table
    // ==================================================

    // First valid entry wins
    always_comb begin
        group_index = '0;
        for (int i = `AGGRE_PIPE_NUM - 1; i >= 0; i--) begin
            if (order_vld[i]) begin
                group_index = pipe_idx_t'(i);
            end
        end
    end

    assign next_pipe = order_pipe[group_index];
    assign rot_index = master_flag ? cfg.master_pipe : group_index;

    // Restart the table just past the served entry
    always_comb begin
        for (int j = 0; j < `AGGRE_PIPE_NUM; j++) begin
            rot_vld[j]  = order_vld[rot_index + pipe_idx_t'(j + 1)];
            rot_pipe[j] = order_pipe[rot_index + pipe_idx_t'(j + 1)];
        end
        rot_vld[`AGGRE_PIPE_NUM-1] = 1'b0;      // Served entry retires at the tail
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            order_vld <= '0;
            for (int i = 0; i < `AGGRE_PIPE_NUM; i++) begin
                order_pipe[i] <= '0;
            end
        end else if ((sch_cs == SCH_SILENT) && start_accept) begin
            order_vld <= cfg.pipe_concat_en;
            for (int i = 0; i < `AGGRE_PIPE_NUM; i++) begin
                order_pipe[i] <= pipe_idx_t'(i);
            end
        end else if ((sch_cs == SCH_WAIT_ACK) && ack_hit) begin
            order_vld  <= rot_vld;
            order_pipe <= rot_pipe;
        end
    end

    // Master position is used for the first rotation of a round
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            master_flag <= 1'b0;
        end else if (sch_cs == SCH_MASTER) begin
            master_flag <= 1'b1;
        end else if ((sch_cs == SCH_WAIT_ACK) && ack_hit) begin
            master_flag <= 1'b0;
        end
    end

    // ==================================================
    // Scheduler FSM
    // ==================================================

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            sch_cs <= SCH_SILENT;
        end else begin
            sch_cs <= sch_ns;
        end
    end

    always_comb begin
        sch_ns = sch_cs;
        case (sch_cs)
            SCH_SILENT:        if (start_accept) sch_ns = SCH_START_CONCAT;
            SCH_START_CONCAT:  sch_ns = SCH_MASTER;
            SCH_MASTER:        sch_ns = SCH_WAIT_ACK;
            SCH_ORDER:         sch_ns = SCH_WAIT_ACK;
            SCH_WAIT_ACK:      if (ack_hit) sch_ns = SCH_CLEAR_STATE;
            SCH_CLEAR_STATE:   sch_ns = SCH_WAIT_LINE_END;
            SCH_WAIT_LINE_END: begin
                if (line_end_hit) begin
                    sch_ns = (|order_vld) ? SCH_ORDER : SCH_SILENT;
                end
            end
            default:           sch_ns = SCH_SILENT;
        endcase
    end

    // Grant level, held until the granted source acks
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            grant <= '0;
        end else if (sch_cs == SCH_START_CONCAT) begin
            grant <= pipe_vec_t'(1) << cfg.master_pipe;
        end else if (sch_cs == SCH_ORDER) begin
            grant <= pipe_vec_t'(1) << next_pipe;
        end else if ((sch_cs == SCH_WAIT_ACK) && ack_hit) begin
            grant <= '0;
        end
    end

    assign up_state     = grant & ~cfg.pipe_mask_bitmap;
    assign bpg_up_state = |(grant & cfg.pipe_mask_bitmap);

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            end_sch_pulse <= 1'b0;
        end else begin
            end_sch_pulse <= (sch_cs == SCH_WAIT_LINE_END) && line_end_hit && !(|order_vld);
        end
    end

endmodule

// File: logic/aggre_datatype_comparator.sv
`timescale 1ns/100ps

`include "aggre_config.svh"

module aggre_datatype_comparator (
    input  aggre_pkg::pipe_dt_t  in_dt [`AGGRE_PIPE_NUM],
    input  aggre_pkg::pipe_vec_t in_sel,
    output logic                 comp_fail
);

    import aggre_pkg::*;

    pipe_vec_t qual;    // Entries that take part in the compare

    always_comb begin
        for (int i = 0; i < `AGGRE_PIPE_NUM; i++) begin
            qual[i] = in_sel[i] & in_dt[i].valid;
        end
    end

    // ==================================================
    // Pairwise compare
    // ==================================================

    // Any qualified pair with different types fails
    always_comb begin
        comp_fail = 1'b0;
        for (int i = 0; i < `AGGRE_PIPE_NUM; i++) begin
            for (int j = i + 1; j < `AGGRE_PIPE_NUM; j++) begin
                if (qual[i] && qual[j] &&
                    (in_dt[i].data_type != in_dt[j].data_type)) begin
                    comp_fail = 1'b1;
                end
            end
        end
    end

    // Single or no qualified entry never fails

endmodule

// File: logic/aggre_pkg.sv
`include "aggre_config.svh"

package aggre_pkg;

    typedef logic [`AGGRE_PIPE_NUM-1:0]         pipe_vec_t;     // One bit per pipe
    typedef logic [$clog2(`AGGRE_PIPE_NUM)-1:0] pipe_idx_t;     // Pipe number
    typedef logic [`AGGRE_DT_WIDTH-1:0]         data_type_t;    // Video data type

    typedef enum logic [1:0] {
        AGGRE_MODE_OFF    = 2'd0,
        AGGRE_MODE_CONCAT = 2'd1,
        AGGRE_MODE_SPLIT  = 2'd2,
        AGGRE_MODE_RSVD   = 2'd3
    } aggre_mode_e;

    // Line scheduler states
    typedef enum logic [2:0] {
        SCH_SILENT        = 3'd0,
        SCH_START_CONCAT  = 3'd1,
        SCH_MASTER        = 3'd2,
        SCH_ORDER         = 3'd3,
        SCH_WAIT_ACK      = 3'd4,
        SCH_CLEAR_STATE   = 3'd5,
        SCH_WAIT_LINE_END = 3'd6
    } sch_state_e;

    typedef struct packed {
        aggre_mode_e aggre_mode;
        pipe_vec_t   pipe_concat_en;    // Pipes taking part in concatenation
        pipe_vec_t   pipe_mask_bitmap;  // Masked pipes go to the BPG
        pipe_idx_t   master_pipe;
        pipe_vec_t   pipe_rdy_bitmap;
    } sch_cfg_t;

    typedef struct packed {
        logic       valid;
        data_type_t data_type;
    } pipe_dt_t;

    // Response of one line source
    typedef struct packed {
        logic ack;
        logic line_end;
    } pipe_evt_t;

endpackage

// File: logic/aggre_config.svh
`ifndef AGGRE_CONFIG_SVH
`define AGGRE_CONFIG_SVH

// ==================================================
// Aggregator pipe and BPG constants
// ==================================================

// Number of video pipes feeding the aggregator
`define AGGRE_PIPE_NUM      4

// Video data type field width
`define AGGRE_DT_WIDTH      6

// BPG grant to ack, in aggre_clk cycles
`define AGGRE_BPG_ACK_DLY   3

// BPG ack to line end, in aggre_clk cycles
`define AGGRE_BPG_LINE_LEN  10

`endif
